// ==== source/id_pkg.sv ====
package id_pkg;

    localparam int NUM_REGS = 32;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] reg_mask_t;   // one bit per register
    typedef logic [5:0]  opcode_t;

    localparam word_t PC_STEP = 32'd4;  // bytes per instruction

    // primary opcodes
    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam opcode_t OP_SW    = 6'b101011;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_ADDI  = 6'b001000;
    localparam opcode_t OP_ORI   = 6'b001101;
    localparam opcode_t OP_LUI   = 6'b001111;
    localparam opcode_t OP_J     = 6'b000010;

    // r-type funct codes
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;

    // why a register is busy, steps toward ST_FREE each cycle
    typedef enum logic [1:0] {
        ST_FREE   = 2'b00,
        ST_RETIRE = 2'b01,   // result on the writeback path
        ST_LOAD   = 2'b10,   // load in flight, not forwardable yet
        ST_ALU    = 2'b11    // alu result available next cycle
    } reg_state_t;

    typedef enum logic [2:0] {
        BP_NONE   = 3'b000,
        BP_ST_WB  = 3'b001,
        BP_A_WB   = 3'b010,
        BP_B_WB   = 3'b011,
        BP_A_ALU  = 3'b100,
        BP_B_ALU  = 3'b101,
        BP_ST_ALU = 3'b110
    } bypass_sel_t;

    typedef struct packed {
        logic        slot;   // producing issue slot, 0 = first
        bypass_sel_t sel;
    } bypass_t;

    typedef enum logic [3:0] {
        ALU_OR  = 4'b0001,
        ALU_ADD = 4'b0010,
        ALU_SUB = 4'b0110
    } alu_op_t;

    typedef struct packed {
        logic [2:0] pc_src;
        logic [3:0] src_sel;    // {srca, srcb}
        alu_op_t    alu_op;
        logic       dmem_en;
        logic       dsrc;       // store data from bypass
        logic       dmem_read;
        logic       reg_write;
        reg_idx_t   dest;
        bypass_t    bypass;
        logic [7:0] reserved;
    } ctrl_word_t;

    typedef struct packed {
        word_t pc1;     // address after inst1
        word_t pc2;
        word_t inst1;
        word_t inst2;
    } fetch_bundle_t;

    typedef struct packed {
        logic       launch;
        reg_idx_t   dest;
        reg_state_t kind;
    } issue_rec_t;

    typedef struct packed {
        reg_state_t [NUM_REGS-1:0] state;
        reg_mask_t                 slot;   // producing slot per register
    } sb_state_t;

    function automatic opcode_t op_of(word_t inst);
        return inst[31:26];
    endfunction

    function automatic reg_idx_t rs_of(word_t inst);
        return inst[25:21];
    endfunction

    function automatic reg_idx_t rt_of(word_t inst);
        return inst[20:16];
    endfunction

    function automatic logic [5:0] funct_of(word_t inst);
        return inst[5:0];
    endfunction

    // register written by the instruction, 0 for none
    function automatic reg_idx_t dest_of(word_t inst);
        case (op_of(inst))
            OP_RTYPE:                       return inst[15:11];
            OP_ADDI, OP_LW, OP_ORI, OP_LUI: return inst[20:16];
            default:                        return '0;
        endcase
    endfunction

endpackage

// ==== source/scoreboard.sv ====
module scoreboard (
    input  logic               CLK,
    input  logic               RST,
    input  id_pkg::issue_rec_t issue1,
    input  id_pkg::issue_rec_t issue2,
    input  id_pkg::reg_mask_t  clr_w_mask,
    output id_pkg::reg_mask_t  busy,
    output id_pkg::sb_state_t  sb_state
);
    id_pkg::reg_mask_t busy_nxt;
    id_pkg::sb_state_t state_nxt;

    always_comb begin
        busy_nxt  = busy;
        state_nxt = sb_state;

        // age every entry one step
        for (int r = 0; r < id_pkg::NUM_REGS; r++) begin
            case (sb_state.state[r])
                id_pkg::ST_ALU, id_pkg::ST_LOAD: begin
                    state_nxt.state[r] = id_pkg::ST_RETIRE;
                end
                id_pkg::ST_RETIRE: begin
                    state_nxt.state[r] = id_pkg::ST_FREE;
                    busy_nxt[r]        = 1'b0;   // written back
                end
                default: ;
            endcase
        end

        // record this cycle's launches, slot 2 recorded last
        if (issue1.launch && issue1.dest != '0) begin
            busy_nxt[issue1.dest]        = 1'b1;
            state_nxt.state[issue1.dest] = issue1.kind;
            state_nxt.slot[issue1.dest]  = 1'b0;
        end
        if (issue2.launch && issue2.dest != '0) begin
            busy_nxt[issue2.dest]        = 1'b1;
            state_nxt.state[issue2.dest] = issue2.kind;
            state_nxt.slot[issue2.dest]  = 1'b1;
        end

        busy_nxt           = busy_nxt & ~clr_w_mask;  // writes completed elsewhere
        busy_nxt[0]        = 1'b0;                    // $zero is never busy
        state_nxt.state[0] = id_pkg::ST_FREE;
        state_nxt.slot[0]  = 1'b0;
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            busy     <= '0;
            sb_state <= '0;
        end else begin
            busy     <= busy_nxt;
            sb_state <= state_nxt;
        end
    end

endmodule

// ==== source/operand_check.sv ====
module operand_check (
    input  id_pkg::word_t      inst,
    input  id_pkg::reg_mask_t  busy,
    input  id_pkg::sb_state_t  sb_state,
    output logic               ok,
    output id_pkg::reg_idx_t   dest,
    output id_pkg::reg_state_t kind,
    output id_pkg::bypass_t    bypass
);
    id_pkg::opcode_t  opcode;
    id_pkg::reg_idx_t rs;
    id_pkg::reg_idx_t rt;
    id_pkg::bypass_t  bp_a;
    id_pkg::bypass_t  bp_b;
    logic             stall_a;
    logic             stall_b;
    logic             src_stall;

    assign opcode = id_pkg::op_of(inst);
    assign rs     = id_pkg::rs_of(inst);
    assign rt     = id_pkg::rt_of(inst);
    assign dest   = id_pkg::dest_of(inst);

    // route one busy alu source, returns 1 when it has to wait
    function automatic logic route_src(input id_pkg::reg_idx_t r, input logic to_b,
                                       output id_pkg::bypass_t bp);
        bp.slot   = sb_state.slot[r];
        bp.sel    = id_pkg::BP_NONE;
        route_src = 1'b0;
        case (sb_state.state[r])
            id_pkg::ST_ALU: begin
                if (to_b) bp.sel = id_pkg::BP_B_ALU;
                else      bp.sel = id_pkg::BP_A_ALU;
            end
            id_pkg::ST_RETIRE: begin
                if (to_b) bp.sel = id_pkg::BP_B_WB;
                else      bp.sel = id_pkg::BP_A_WB;
            end
            default: route_src = 1'b1;   // load data not there yet
        endcase
    endfunction

    always_comb begin
        stall_a = route_src(rs, 1'b0, bp_a);
        stall_b = route_src(rt, 1'b1, bp_b);
    end

    always_comb begin
        src_stall = 1'b0;
        bypass    = '0;
        case (opcode)
            id_pkg::OP_RTYPE, id_pkg::OP_BEQ: begin
                if (busy[rs] && busy[rt]) begin
                    src_stall = 1'b1;   // only one bypass per instruction
                end else if (busy[rs]) begin
                    src_stall = stall_a;
                    bypass    = bp_a;
                end else if (busy[rt]) begin
                    src_stall = stall_b;
                    bypass    = bp_b;
                end
            end
            id_pkg::OP_ADDI, id_pkg::OP_ORI, id_pkg::OP_LW: begin
                if (busy[rs]) begin
                    src_stall = stall_a;
                    bypass    = bp_a;
                end
            end
            id_pkg::OP_SW: begin
                if (busy[rs]) begin
                    src_stall = 1'b1;   // address base must be settled
                end else if (busy[rt]) begin
                    bypass.slot = sb_state.slot[rt];
                    case (sb_state.state[rt])
                        id_pkg::ST_ALU, id_pkg::ST_LOAD: bypass.sel = id_pkg::BP_ST_ALU;
                        id_pkg::ST_RETIRE:               bypass.sel = id_pkg::BP_ST_WB;
                        default:                         src_stall  = 1'b1;
                    endcase
                end
            end
            default: ;   // lui, j and illegal read nothing
        endcase
    end

    always_comb begin
        case (opcode)
            id_pkg::OP_LW: kind = id_pkg::ST_LOAD;
            id_pkg::OP_RTYPE, id_pkg::OP_ADDI, id_pkg::OP_ORI, id_pkg::OP_LUI: begin
                kind = id_pkg::ST_ALU;
            end
            default: kind = id_pkg::ST_FREE;
        endcase
    end

    assign ok = !busy[dest] && !src_stall;   // busy[0] is always clear

endmodule

// ==== source/main_decoder.sv ====
module main_decoder (
    input  id_pkg::word_t      inst,
    input  id_pkg::bypass_t    bypass,
    output id_pkg::ctrl_word_t ctrl
);
    id_pkg::opcode_t opcode;
    logic            legal;
    logic            writer;

    assign opcode = id_pkg::op_of(inst);

    always_comb begin
        ctrl   = '0;
        legal  = 1'b1;
        writer = 1'b0;
        case (opcode)
            id_pkg::OP_RTYPE: begin
                legal        = (inst != '0);   // all-zero word is a bubble
                writer       = 1'b1;
                ctrl.pc_src  = 3'd1;
                ctrl.src_sel = 4'd5;           // rs, rt
                case (id_pkg::funct_of(inst))
                    id_pkg::FN_ADD, id_pkg::FN_ADDU: ctrl.alu_op = id_pkg::ALU_ADD;
                    id_pkg::FN_SUB, id_pkg::FN_SUBU: ctrl.alu_op = id_pkg::ALU_SUB;
                    default:                         ctrl.alu_op = id_pkg::ALU_ADD;
                endcase
            end
            id_pkg::OP_LW, id_pkg::OP_ADDI: begin
                writer       = 1'b1;
                ctrl.pc_src  = 3'd1;
                ctrl.src_sel = 4'd6;           // rs, imm
                ctrl.alu_op  = id_pkg::ALU_ADD;
            end
            id_pkg::OP_SW: begin
                ctrl.pc_src  = 3'd1;
                ctrl.src_sel = 4'd6;
                ctrl.alu_op  = id_pkg::ALU_ADD;
            end
            id_pkg::OP_BEQ: begin
                ctrl.pc_src  = 3'd3;           // compare and branch
                ctrl.src_sel = 4'd5;
                ctrl.alu_op  = id_pkg::ALU_SUB;
            end
            id_pkg::OP_ORI: begin
                writer       = 1'b1;
                ctrl.pc_src  = 3'd0;           // zero-extended imm
                ctrl.src_sel = 4'd6;
                ctrl.alu_op  = id_pkg::ALU_OR;
            end
            id_pkg::OP_LUI: begin
                writer       = 1'b1;
                ctrl.pc_src  = 3'd1;
                ctrl.src_sel = 4'd2;           // zero + imm
                ctrl.alu_op  = id_pkg::ALU_ADD;
            end
            id_pkg::OP_J: begin
                ctrl.pc_src  = 3'd5;
                ctrl.alu_op  = id_pkg::ALU_ADD;
            end
            default: legal = 1'b0;
        endcase

        ctrl.dmem_en   = (opcode == id_pkg::OP_LW) || (opcode == id_pkg::OP_SW);
        ctrl.dmem_read = (opcode != id_pkg::OP_SW);
        ctrl.reg_write = writer;
        ctrl.dest      = id_pkg::dest_of(inst);
        ctrl.bypass    = bypass;

        // forwarded operands override the regfile source
        case (bypass.sel)
            id_pkg::BP_A_WB, id_pkg::BP_A_ALU: ctrl.src_sel[3:2] = 2'b11;
            id_pkg::BP_B_WB, id_pkg::BP_B_ALU: ctrl.src_sel[1:0] = 2'b11;
            id_pkg::BP_ST_ALU:                 ctrl.dsrc         = 1'b1;
            default: ;
        endcase

        if (!legal) begin
            ctrl = '0;
        end
    end

endmodule

// ==== source/issue_ctrl.sv ====
module issue_ctrl (
    input  logic                  CLK,
    input  logic                  RST,
    input  id_pkg::fetch_bundle_t fetch,
    input  logic                  ok1,
    input  logic                  ok2,
    input  id_pkg::reg_idx_t      dest1,
    input  id_pkg::reg_idx_t      dest2,
    input  id_pkg::reg_state_t    kind1,
    input  id_pkg::reg_state_t    kind2,
    input  id_pkg::ctrl_word_t    ctrl_in1,
    input  id_pkg::ctrl_word_t    ctrl_in2,
    input  logic                  ex_set_pc,
    input  id_pkg::word_t         ex_pc,
    output id_pkg::fetch_bundle_t bundle,
    output id_pkg::issue_rec_t    issue1,
    output id_pkg::issue_rec_t    issue2,
    output id_pkg::ctrl_word_t    ctrl1,
    output id_pkg::ctrl_word_t    ctrl2,
    output logic                  id_set_pc,
    output id_pkg::word_t         id_pc
);
    logic          launch1;
    logic          launch2;
    logic          pair_dep;
    logic          set_pc_nxt;
    id_pkg::word_t pc_nxt;

    // fetch pair captured every cycle, no back-pressure
    always_ff @(posedge CLK) begin
        if (RST) begin
            bundle <= '0;
        end else begin
            bundle <= fetch;
        end
    end

    // slot 2 may not overlap slot 1's result in the same pair
    assign pair_dep = (dest1 != '0) &&
                      ((dest2 == dest1) ||
                       (id_pkg::rs_of(bundle.inst2) == dest1) ||
                       (id_pkg::rt_of(bundle.inst2) == dest1));

    assign launch1 = ok1 && !ex_set_pc;           // execute override squashes both
    assign launch2 = launch1 && ok2 && !pair_dep;

    assign issue1 = '{launch: launch1, dest: dest1, kind: kind1};
    assign issue2 = '{launch: launch2, dest: dest2, kind: kind2};

    always_comb begin
        if (ex_set_pc) begin
            set_pc_nxt = 1'b1;
            pc_nxt     = ex_pc;
        end else if (launch2) begin
            set_pc_nxt = 1'b0;
            pc_nxt     = bundle.pc2;   // sequential, fetch not redirected
        end else if (launch1) begin
            set_pc_nxt = 1'b1;
            pc_nxt     = bundle.pc1;   // refetch slot 2
        end else begin
            set_pc_nxt = 1'b1;
            pc_nxt     = bundle.pc1 - id_pkg::PC_STEP;   // refetch whole pair
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            ctrl1     <= '0;
            ctrl2     <= '0;
            id_set_pc <= 1'b0;
        end else begin
            ctrl1     <= launch1 ? ctrl_in1 : '0;
            ctrl2     <= launch2 ? ctrl_in2 : '0;
            id_set_pc <= set_pc_nxt;
        end
    end

    always_ff @(posedge CLK) begin
        id_pc <= pc_nxt;
    end

endmodule

// ==== source/id_stage.sv ====
module id_stage (
    input  logic                  CLK,
    input  logic                  RST,
    input  id_pkg::fetch_bundle_t fetch,
    input  id_pkg::reg_mask_t     clr_w_mask,
    input  logic                  ex_set_pc,
    input  id_pkg::word_t         ex_pc,
    output id_pkg::ctrl_word_t    ctrl1,
    output id_pkg::ctrl_word_t    ctrl2,
    output logic                  id_set_pc,
    output id_pkg::word_t         id_pc
);
    id_pkg::fetch_bundle_t bundle;
    id_pkg::reg_mask_t     busy;
    id_pkg::sb_state_t     sb_state;
    id_pkg::issue_rec_t    issue1;
    id_pkg::issue_rec_t    issue2;
    logic                  ok1;
    logic                  ok2;
    id_pkg::reg_idx_t      dest1;
    id_pkg::reg_idx_t      dest2;
    id_pkg::reg_state_t    kind1;
    id_pkg::reg_state_t    kind2;
    id_pkg::bypass_t       bp1;
    id_pkg::bypass_t       bp2;
    id_pkg::ctrl_word_t    dec1;
    id_pkg::ctrl_word_t    dec2;

    issue_ctrl u_issue (
        .CLK       (CLK),
        .RST       (RST),
        .fetch     (fetch),
        .ok1       (ok1),
        .ok2       (ok2),
        .dest1     (dest1),
        .dest2     (dest2),
        .kind1     (kind1),
        .kind2     (kind2),
        .ctrl_in1  (dec1),
        .ctrl_in2  (dec2),
        .ex_set_pc (ex_set_pc),
        .ex_pc     (ex_pc),
        .bundle    (bundle),
        .issue1    (issue1),
        .issue2    (issue2),
        .ctrl1     (ctrl1),
        .ctrl2     (ctrl2),
        .id_set_pc (id_set_pc),
        .id_pc     (id_pc)
    );

    scoreboard u_sb (
        .CLK        (CLK),
        .RST        (RST),
        .issue1     (issue1),
        .issue2     (issue2),
        .clr_w_mask (clr_w_mask),
        .busy       (busy),
        .sb_state   (sb_state)
    );

    operand_check u_chk1 (.inst(bundle.inst1), .busy(busy), .sb_state(sb_state),
                          .ok(ok1), .dest(dest1), .kind(kind1), .bypass(bp1));
    operand_check u_chk2 (.inst(bundle.inst2), .busy(busy), .sb_state(sb_state),
                          .ok(ok2), .dest(dest2), .kind(kind2), .bypass(bp2));

    main_decoder u_dec1 (.inst(bundle.inst1), .bypass(bp1), .ctrl(dec1));
    main_decoder u_dec2 (.inst(bundle.inst2), .bypass(bp2), .ctrl(dec2));

endmodule

// ==== verification/id_stage_chk.sv ====
module id_stage_chk (
    input logic                  CLK,
    input logic                  RST,
    input id_pkg::fetch_bundle_t fetch,
    input logic                  ex_set_pc,
    input id_pkg::word_t         ex_pc,
    input id_pkg::ctrl_word_t    ctrl1,
    input id_pkg::ctrl_word_t    ctrl2,
    input logic                  id_set_pc,
    input id_pkg::word_t         id_pc
);
    int unsigned           fails = 0;
    id_pkg::fetch_bundle_t hist [1:7];   // hist[k] = fetch k edges back
    logic [3:1]            ex_hist;
    id_pkg::word_t         ex_pc_q;
    id_pkg::fetch_bundle_t b;            // bundle whose result is on the outputs now
    logic                  calm;
    logic                  quiet;
    logic                  pair_ok;
    logic                  indep;
    logic                  add_ahead;
    logic                  lw_ahead;
    logic                  lw_repeat;
    logic [1:0]            rd_alu;
    logic [1:0]            rd_wb;
    id_pkg::bypass_t       exp_alu_bp;
    id_pkg::bypass_t       exp_wb_bp;

    function automatic logic is_legal(id_pkg::word_t i);
        case (i[31:26])
            id_pkg::OP_RTYPE: return i != '0;
            id_pkg::OP_LW, id_pkg::OP_SW, id_pkg::OP_BEQ, id_pkg::OP_ADDI,
            id_pkg::OP_ORI, id_pkg::OP_LUI, id_pkg::OP_J: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic id_pkg::reg_idx_t dest_reg(id_pkg::word_t i);
        if (i[31:26] == id_pkg::OP_RTYPE) return i[15:11];
        if (i[31:26] inside {id_pkg::OP_LW, id_pkg::OP_ADDI, id_pkg::OP_ORI, id_pkg::OP_LUI})
            return i[20:16];
        return '0;
    endfunction

    // {reads as rs, reads as rt}
    function automatic logic [1:0] reads_reg(id_pkg::word_t i, id_pkg::reg_idx_t d);
        return {i[25:21] == d, i[20:16] == d};
    endfunction

    function automatic logic zero_pair(id_pkg::fetch_bundle_t f);
        return f.inst1 == '0 && f.inst2 == '0;
    endfunction

    // field table per opcode, no bypass
    function automatic id_pkg::ctrl_word_t expect_ctrl(id_pkg::word_t i);
        id_pkg::ctrl_word_t c;
        c = '0;
        if (!is_legal(i)) return c;
        c.dmem_read = 1'b1;
        c.pc_src    = 3'd1;
        c.src_sel   = 4'd6;
        c.alu_op    = id_pkg::ALU_ADD;
        case (i[31:26])
            id_pkg::OP_RTYPE: begin
                c.src_sel = 4'd5;
                if (i[5:0] == id_pkg::FN_SUB || i[5:0] == id_pkg::FN_SUBU)
                    c.alu_op = id_pkg::ALU_SUB;
            end
            id_pkg::OP_LW:  c.dmem_en = 1'b1;
            id_pkg::OP_SW: begin
                c.dmem_en   = 1'b1;
                c.dmem_read = 1'b0;
            end
            id_pkg::OP_BEQ: begin
                c.pc_src  = 3'd3;
                c.src_sel = 4'd5;
                c.alu_op  = id_pkg::ALU_SUB;
            end
            id_pkg::OP_ORI: begin
                c.pc_src = 3'd0;
                c.alu_op = id_pkg::ALU_OR;
            end
            id_pkg::OP_LUI: c.src_sel = 4'd2;
            id_pkg::OP_J: begin
                c.pc_src  = 3'd5;
                c.src_sel = 4'd0;
            end
            default: ;
        endcase
        c.dest      = dest_reg(i);
        c.reg_write = i[31:26] inside {id_pkg::OP_RTYPE, id_pkg::OP_LW, id_pkg::OP_ADDI,
                                       id_pkg::OP_ORI, id_pkg::OP_LUI};
        return c;
    endfunction

    // producer in slot 1 alone, consumer r-type in slot 1 reading it once
    function automatic logic dep_single(id_pkg::fetch_bundle_t prod,
                                        id_pkg::fetch_bundle_t cons, id_pkg::opcode_t op);
        id_pkg::reg_idx_t d;
        d = dest_reg(prod.inst1);
        if (prod.inst1[31:26] != op || prod.inst2 != '0 || d == '0) return 1'b0;
        if (op == id_pkg::OP_RTYPE && prod.inst1[5:0] != id_pkg::FN_ADD) return 1'b0;
        return cons.inst1[31:26] == id_pkg::OP_RTYPE && cons.inst2 == '0 &&
               ^reads_reg(cons.inst1, d) && dest_reg(cons.inst1) != d;
    endfunction

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int k = 1; k <= 7; k++) hist[k] <= '0;
            ex_hist <= '0;
            ex_pc_q <= '0;
        end else begin
            hist[1] <= fetch;
            for (int k = 2; k <= 7; k++) hist[k] <= hist[k-1];
            ex_hist <= {ex_hist[2:1], ex_set_pc};
            ex_pc_q <= ex_pc;
        end
    end

    always_comb begin
        b         = hist[2];
        calm      = ex_hist == '0;
        quiet     = zero_pair(hist[3]) && zero_pair(hist[4]) && zero_pair(hist[5]);
        pair_ok   = is_legal(b.inst1) && is_legal(b.inst2);
        indep     = dest_reg(b.inst1) == '0 ||
                    (dest_reg(b.inst2) != dest_reg(b.inst1) &&
                     reads_reg(b.inst2, dest_reg(b.inst1)) == 2'b00);
        add_ahead = dep_single(hist[3], b, id_pkg::OP_RTYPE) &&
                    zero_pair(hist[4]) && zero_pair(hist[5]) && zero_pair(hist[6]);
        lw_ahead  = dep_single(hist[3], b, id_pkg::OP_LW) &&
                    zero_pair(hist[4]) && zero_pair(hist[5]) && zero_pair(hist[6]);
        lw_repeat = hist[2] == hist[3] && dep_single(hist[4], b, id_pkg::OP_LW) &&
                    zero_pair(hist[5]) && zero_pair(hist[6]) && zero_pair(hist[7]);
        rd_alu    = reads_reg(b.inst1, dest_reg(hist[3].inst1));
        rd_wb     = reads_reg(b.inst1, dest_reg(hist[4].inst1));
        exp_alu_bp.slot = 1'b0;
        exp_alu_bp.sel  = rd_alu[1] ? id_pkg::BP_A_ALU : id_pkg::BP_B_ALU;
        exp_wb_bp.slot  = 1'b0;
        exp_wb_bp.sel   = rd_wb[1] ? id_pkg::BP_A_WB : id_pkg::BP_B_WB;
    end

    a_ctrl1_issue: assert property (@(posedge CLK) disable iff (RST)
        calm && quiet && pair_ok && indep |-> ctrl1 == expect_ctrl(b.inst1))
        else begin
            $error("FAIL t=%0t ctrl1 exp=%h got=%h", $time, expect_ctrl(b.inst1), ctrl1);
            fails++;
        end

    a_ctrl2_issue: assert property (@(posedge CLK) disable iff (RST)
        calm && quiet && pair_ok && indep |-> ctrl2 == expect_ctrl(b.inst2))
        else begin
            $error("FAIL t=%0t ctrl2 exp=%h got=%h", $time, expect_ctrl(b.inst2), ctrl2);
            fails++;
        end

    a_no_redirect: assert property (@(posedge CLK) disable iff (RST)
        calm && quiet && pair_ok && indep |-> !id_set_pc)
        else begin
            $error("FAIL t=%0t id_set_pc exp=0 got=%b", $time, id_set_pc);
            fails++;
        end

    a_pair_hold: assert property (@(posedge CLK) disable iff (RST)
        calm && quiet && pair_ok && !indep |-> ctrl2 == '0 && id_set_pc && id_pc == b.pc1)
        else begin
            $error("FAIL t=%0t id_pc exp=%h got=%h (ctrl2=%h id_set_pc=%b)",
                   $time, b.pc1, id_pc, ctrl2, id_set_pc);
            fails++;
        end

    a_alu_bypass: assert property (@(posedge CLK) disable iff (RST)
        calm && add_ahead |-> ctrl1.bypass == exp_alu_bp &&
        (rd_alu[1] ? ctrl1.src_sel[3:2] == 2'b11 : ctrl1.src_sel[1:0] == 2'b11))
        else begin
            $error("FAIL t=%0t ctrl1.bypass exp=%h got=%h (src_sel=%h)",
                   $time, exp_alu_bp, ctrl1.bypass, ctrl1.src_sel);
            fails++;
        end

    a_load_stall: assert property (@(posedge CLK) disable iff (RST)
        calm && lw_ahead |-> ctrl1 == '0 && ctrl2 == '0 && id_set_pc &&
        id_pc == b.pc1 - 32'd4)
        else begin
            $error("FAIL t=%0t id_pc exp=%h got=%h (ctrl1=%h ctrl2=%h id_set_pc=%b)",
                   $time, b.pc1 - 32'd4, id_pc, ctrl1, ctrl2, id_set_pc);
            fails++;
        end

    a_wb_bypass: assert property (@(posedge CLK) disable iff (RST)
        calm && lw_repeat |-> ctrl1.bypass == exp_wb_bp)
        else begin
            $error("FAIL t=%0t ctrl1.bypass exp=%h got=%h", $time, exp_wb_bp, ctrl1.bypass);
            fails++;
        end

    a_ex_override: assert property (@(posedge CLK) disable iff (RST)
        ex_hist[1] |-> ctrl1 == '0 && ctrl2 == '0 && id_set_pc && id_pc == ex_pc_q)
        else begin
            $error("FAIL t=%0t id_pc exp=%h got=%h (ctrl1=%h ctrl2=%h id_set_pc=%b)",
                   $time, ex_pc_q, id_pc, ctrl1, ctrl2, id_set_pc);
            fails++;
        end

    a_illegal: assert property (@(posedge CLK) disable iff (RST)
        calm && b.inst1 != '0 && !is_legal(b.inst1) |-> ctrl1 == '0)
        else begin
            $error("FAIL t=%0t ctrl1 exp=0 got=%h", $time, ctrl1);
            fails++;
        end

endmodule

// ==== verification/tb_id_stage.sv ====
module tb_id_stage;

    localparam int MAX_CYCLES = 200;   // tests need about 65

    logic                  CLK;
    logic                  RST;
    id_pkg::fetch_bundle_t fetch;
    id_pkg::reg_mask_t     clr_w_mask;
    logic                  ex_set_pc;
    id_pkg::word_t         ex_pc;
    id_pkg::ctrl_word_t    ctrl1;
    id_pkg::ctrl_word_t    ctrl2;
    logic                  id_set_pc;
    id_pkg::word_t         id_pc;

    int unsigned      cycles = 0;
    int unsigned      lcg_state = 16;
    id_pkg::word_t    pc = 32'h0000_1000;
    id_pkg::reg_idx_t r [0:5];   // distinct nonzero registers for one case

    id_stage dut0 (.*);

    bind id_stage id_stage_chk u_chk (
        .CLK(CLK), .RST(RST), .fetch(fetch), .ex_set_pc(ex_set_pc), .ex_pc(ex_pc),
        .ctrl1(ctrl1), .ctrl2(ctrl2), .id_set_pc(id_set_pc), .id_pc(id_pc)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic int unsigned lcg_next(int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic id_pkg::word_t rtype(id_pkg::reg_idx_t rs, id_pkg::reg_idx_t rt,
                                            id_pkg::reg_idx_t rd, logic [5:0] fn);
        return {id_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic id_pkg::word_t itype(id_pkg::opcode_t op, id_pkg::reg_idx_t rs,
                                            id_pkg::reg_idx_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic pick_regs();
        int unsigned base;
        lcg_state = lcg_next(lcg_state);
        base = (lcg_state >> 16) % 31;
        for (int k = 0; k < 6; k++) r[k] = id_pkg::reg_idx_t'(((base + k) % 31) + 1);
    endtask

    // one bundle for one cycle, driven 10 after the edge
    task automatic apply(id_pkg::word_t i1, id_pkg::word_t i2);
        fetch.pc1   = pc + 32'd4;
        fetch.pc2   = pc + 32'd8;
        fetch.inst1 = i1;
        fetch.inst2 = i2;
        pc          = pc + 32'd8;
        @(posedge CLK);
        #10;
    endtask

    // same bundle again, as fetch re-presents it after a redirect
    task automatic reapply();
        @(posedge CLK);
        #10;
    endtask

    task automatic quiet();
        repeat (3) apply('0, '0);
    endtask

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("TB FAILED");
            $fatal(1, "run did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    // stop at the first assertion failure
    always @(negedge CLK) begin
        if (dut0.u_chk.fails != 0) begin
            $display("TB FAILED");
            $fatal(1, "assertion failure in id_stage_chk");
        end
    end

    initial begin
        RST        = 1'b1;
        fetch      = '0;
        clr_w_mask = '0;
        ex_set_pc  = 1'b0;
        ex_pc      = '0;
        repeat (8) @(posedge CLK);
        #10 RST = 1'b0;

        // independent pairs, one per opcode class
        pick_regs(); quiet();
        apply(rtype(r[0], r[1], r[2], id_pkg::FN_ADD), itype(id_pkg::OP_SW, r[3], r[4], 16'h10));
        pick_regs(); quiet();
        apply(rtype(r[0], r[1], r[2], id_pkg::FN_SUB), itype(id_pkg::OP_BEQ, r[3], r[4], 16'h8));
        pick_regs(); quiet();
        apply(itype(id_pkg::OP_LW, r[0], r[1], 16'h20), itype(id_pkg::OP_ADDI, r[2], r[3], 16'h5));
        pick_regs(); quiet();
        apply(itype(id_pkg::OP_ORI, r[0], r[1], 16'hff), itype(id_pkg::OP_LUI, 5'd0, r[2], 16'h1));
        pick_regs(); quiet();
        apply({id_pkg::OP_J, 26'h40}, rtype(r[0], r[1], r[2], id_pkg::FN_ADDU));

        // same destination, then slot 2 reading slot 1
        pick_regs(); quiet();
        apply(itype(id_pkg::OP_ADDI, r[0], r[1], 16'h3), itype(id_pkg::OP_ORI, r[2], r[1], 16'h7));
        pick_regs(); quiet();
        apply(rtype(r[0], r[1], r[2], id_pkg::FN_ADD), rtype(r[2], r[3], r[4], id_pkg::FN_SUB));

        // alu forwarding into operand a, then b
        pick_regs(); quiet();
        apply(rtype(r[0], r[1], r[2], id_pkg::FN_ADD), '0);
        apply(rtype(r[2], r[3], r[4], id_pkg::FN_ADD), '0);
        pick_regs(); quiet();
        apply(rtype(r[0], r[1], r[2], id_pkg::FN_ADD), '0);
        apply(rtype(r[3], r[2], r[4], id_pkg::FN_SUB), '0);

        // load-use stall, same bundle again gets writeback forwarding
        pick_regs(); quiet();
        apply(itype(id_pkg::OP_LW, r[0], r[1], 16'h4), '0);
        apply(rtype(r[1], r[2], r[3], id_pkg::FN_ADD), '0);
        reapply();

        // execute override while the pair is judged
        pick_regs(); quiet();
        apply(rtype(r[0], r[1], r[2], id_pkg::FN_ADD), itype(id_pkg::OP_ADDI, r[3], r[4], 16'h2));
        ex_set_pc = 1'b1;
        ex_pc     = 32'h0000_4000;
        apply('0, '0);
        ex_set_pc = 1'b0;

        // illegal opcode in slot 1
        quiet();
        apply({6'b111111, 26'h123}, '0);
        quiet();

        if (dut0.u_chk.fails == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("TB FAILED");
            $fatal(1, "assertion failures seen");
        end
    end

endmodule

// ==== sources.f ====
source/id_pkg.sv
source/scoreboard.sv
source/operand_check.sv
source/main_decoder.sv
source/issue_ctrl.sv
source/id_stage.sv
verification/id_stage_chk.sv
verification/tb_id_stage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the id_stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_id_stage \
    -f sources.f -o sim_tb > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1

grep -q "TB PASSED" sim.log && echo "simulation ok" || { echo "simulation failed, see sim.log"; exit 1; }
